/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_decode_stage
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
types_pkg.sv
control_unit_if.sv
instr_fetch_reg.sv
control_unit.sv
issue_router.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

/* control_unit.sv */
// combinational decoder for rv32i plus the matrix instructions
// ld.m, st.m and gemm.m
module control_unit (
    control_unit_if.cu cu_if
);

    types_pkg::opcode_t opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;

    assign opcode = cu_if.instr[6:0];
    assign funct3 = cu_if.instr[14:12];
    assign funct7 = cu_if.instr[31:25];

    always_comb
    begin
        // everything off unless the opcode says otherwise
        cu_if.halt        = 1'b0;
        cu_if.i_flag      = 1'b0;
        cu_if.reg_write   = 1'b0;
        cu_if.jal         = 1'b0;
        cu_if.jalr        = 1'b0;
        cu_if.s_mem_type  = types_pkg::MEM_NONE;
        cu_if.u_type      = types_pkg::U_NONE;
        cu_if.alu_op      = types_pkg::ALU_ADD;
        cu_if.branch_type = types_pkg::BR_NONE;
        cu_if.imm         = '0;
        cu_if.fu_s        = types_pkg::FU_NONE;
        cu_if.fu_m        = types_pkg::FU_NONE;
        cu_if.m_mem_type  = types_pkg::MEM_NONE;
        cu_if.stride      = '0;
        cu_if.matrix_rd   = '0;
        cu_if.matrix_rs1  = '0;

        case (opcode)
            types_pkg::RTYPE:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.fu_s      = types_pkg::FU_ALU;
                case (funct3)
                    types_pkg::ADD_SUB:
                        cu_if.alu_op = (funct7 == types_pkg::SUB) ?
                                       types_pkg::ALU_SUB : types_pkg::ALU_ADD;
                    types_pkg::SRL_SRA:
                        cu_if.alu_op = (funct7 == types_pkg::SRA) ?
                                       types_pkg::ALU_SRA : types_pkg::ALU_SRL;
                    types_pkg::SLL:  cu_if.alu_op = types_pkg::ALU_SLL;
                    types_pkg::SLT:  cu_if.alu_op = types_pkg::ALU_SLT;
                    types_pkg::SLTU: cu_if.alu_op = types_pkg::ALU_SLTU;
                    types_pkg::XOR:  cu_if.alu_op = types_pkg::ALU_XOR;
                    types_pkg::OR:   cu_if.alu_op = types_pkg::ALU_OR;
                    default:         cu_if.alu_op = types_pkg::ALU_AND;
                endcase
            end
            types_pkg::ITYPE:
            begin
                cu_if.reg_write = 1'b1;
                cu_if.i_flag    = 1'b1;
                cu_if.fu_s      = types_pkg::FU_ALU;
                cu_if.imm       = {{20{cu_if.instr[31]}}, cu_if.instr[31:20]};
                // no subi, only the shift uses funct7
                case (funct3)
                    types_pkg::SRL_SRA:
                        cu_if.alu_op = (funct7 == types_pkg::SRA) ?
                                       types_pkg::ALU_SRA : types_pkg::ALU_SRL;
                    types_pkg::ADD_SUB: cu_if.alu_op = types_pkg::ALU_ADD;
                    types_pkg::SLL:     cu_if.alu_op = types_pkg::ALU_SLL;
                    types_pkg::SLT:     cu_if.alu_op = types_pkg::ALU_SLT;
                    types_pkg::SLTU:    cu_if.alu_op = types_pkg::ALU_SLTU;
                    types_pkg::XOR:     cu_if.alu_op = types_pkg::ALU_XOR;
                    types_pkg::OR:      cu_if.alu_op = types_pkg::ALU_OR;
                    default:            cu_if.alu_op = types_pkg::ALU_AND;
                endcase
            end
            types_pkg::ITYPE_LW:
            begin
                // lw only, other widths stay illegal
                if (funct3 == types_pkg::LW_SW)
                begin
                    cu_if.reg_write  = 1'b1;
                    cu_if.i_flag     = 1'b1;
                    cu_if.s_mem_type = types_pkg::MEM_LOAD;
                    cu_if.fu_s       = types_pkg::FU_LD_ST;
                    cu_if.imm        = {{20{cu_if.instr[31]}}, cu_if.instr[31:20]};
                end
            end
            types_pkg::STYPE:
            begin
                if (funct3 == types_pkg::LW_SW)
                begin
                    cu_if.i_flag     = 1'b1;
                    cu_if.s_mem_type = types_pkg::MEM_STORE;
                    cu_if.fu_s       = types_pkg::FU_LD_ST;
                    cu_if.imm        = {{20{cu_if.instr[31]}}, cu_if.instr[31:25],
                                        cu_if.instr[11:7]};
                end
            end
            types_pkg::BTYPE:
            begin
                cu_if.fu_s = types_pkg::FU_BRANCH;
                cu_if.imm  = {{20{cu_if.instr[31]}}, cu_if.instr[7],
                              cu_if.instr[30:25], cu_if.instr[11:8], 1'b0};
                // funct3 2 and 3 keep br_none
                case (funct3)
                    types_pkg::BEQ:  cu_if.branch_type = types_pkg::BR_BEQ;
                    types_pkg::BNE:  cu_if.branch_type = types_pkg::BR_BNE;
                    types_pkg::BLT:  cu_if.branch_type = types_pkg::BR_BLT;
                    types_pkg::BGE:  cu_if.branch_type = types_pkg::BR_BGE;
                    types_pkg::BLTU: cu_if.branch_type = types_pkg::BR_BLTU;
                    types_pkg::BGEU: cu_if.branch_type = types_pkg::BR_BGEU;
                    default:         cu_if.branch_type = types_pkg::BR_NONE;
                endcase
            end
            types_pkg::JAL:
            begin
                cu_if.jal       = 1'b1;
                cu_if.reg_write = 1'b1;
                cu_if.i_flag    = 1'b1;
                cu_if.fu_s      = types_pkg::FU_ALU;
                cu_if.imm       = {{12{cu_if.instr[31]}}, cu_if.instr[19:12],
                                   cu_if.instr[20], cu_if.instr[30:21], 1'b0};
            end
            types_pkg::JALR:
            begin
                cu_if.jalr      = 1'b1;
                cu_if.reg_write = 1'b1;
                cu_if.i_flag    = 1'b1;
                cu_if.fu_s      = types_pkg::FU_ALU;
                cu_if.imm       = {{20{cu_if.instr[31]}}, cu_if.instr[31:20]};
            end
            types_pkg::LUI:
            begin
                // no functional unit, issues through reg_write
                cu_if.reg_write = 1'b1;
                cu_if.u_type    = types_pkg::U_LOAD;
                cu_if.imm       = {cu_if.instr[31:12], 12'b0};
            end
            types_pkg::HALT:
            begin
                cu_if.halt = 1'b1;
            end
            types_pkg::LD_M, types_pkg::ST_M:
            begin
                cu_if.fu_m       = types_pkg::FU_LD_ST;
                cu_if.m_mem_type = (opcode == types_pkg::LD_M) ?
                                   types_pkg::MEM_LOAD : types_pkg::MEM_STORE;
                cu_if.imm        = {{21{cu_if.instr[17]}}, cu_if.instr[17:7]};
                // stride names a scalar register
                cu_if.stride     = cu_if.instr[22:18];
                cu_if.matrix_rd  = cu_if.instr[31:28];
                cu_if.matrix_rs1 = cu_if.instr[27:23];
            end
            types_pkg::GEMM_M:
            begin
                // md = ma @ mb + mc, operands implied
                cu_if.fu_m = types_pkg::FU_GEMM;
            end
            default:
            begin
                // unknown opcode, all fields stay zero
            end
        endcase
    end

endmodule

/* control_unit_if.sv */
// decode bus between the fetch register, the control unit and the
// issue router
interface control_unit_if;

    // fetch side
    types_pkg::word_t     instr;
    logic                 instr_valid;

    // decoded scalar controls
    logic                 halt;
    logic                 i_flag;
    logic                 reg_write;
    logic                 jal;
    logic                 jalr;
    types_pkg::mem_t      s_mem_type;
    types_pkg::u_type_t   u_type;
    types_pkg::alu_op_t   alu_op;
    types_pkg::branch_t   branch_type;
    types_pkg::word_t     imm;
    types_pkg::fu_t       fu_s;

    // decoded matrix controls
    types_pkg::fu_t       fu_m;
    types_pkg::mem_t      m_mem_type;
    types_pkg::reg_idx_t  stride;
    types_pkg::mreg_idx_t matrix_rd;
    types_pkg::reg_idx_t  matrix_rs1;

    // fetch needs halt back to stop accepting
    modport fetch (
        output instr, instr_valid,
        input  halt
    );

    modport cu (
        input  instr,
        output halt, i_flag, s_mem_type, reg_write, jal, jalr, u_type,
               alu_op, branch_type, imm, stride, fu_s, fu_m, m_mem_type,
               matrix_rd, matrix_rs1
    );

    modport issue (
        input  instr_valid, halt, i_flag, s_mem_type, reg_write, jal, jalr,
               u_type, alu_op, branch_type, imm, stride, fu_s, fu_m,
               m_mem_type, matrix_rd, matrix_rs1
    );

endinterface

/* decode_stage.sv */
// decode stage top level
// fetch register, control unit and issue router joined by the decode bus
module decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  types_pkg::word_t      in_instr,
    output logic                  s_issue,
    output logic                  m_issue,
    output logic                  illegal,
    output logic                  halted,
    output types_pkg::alu_op_t    alu_op,
    output types_pkg::fu_t        fu_s,
    output types_pkg::fu_t        fu_m,
    output types_pkg::branch_t    branch_type,
    output types_pkg::mem_t       s_mem_type,
    output types_pkg::mem_t       m_mem_type,
    output types_pkg::word_t      imm,
    output logic                  reg_write,
    output logic                  i_flag,
    output logic                  jal,
    output logic                  jalr,
    output types_pkg::u_type_t    u_type,
    output types_pkg::reg_idx_t   stride,
    output types_pkg::reg_idx_t   matrix_rs1,
    output types_pkg::mreg_idx_t  matrix_rd
);

    control_unit_if cu_bus ();

    // stage 1, input register
    instr_fetch_reg fetch0 (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_instr (in_instr),
        .fe_if    (cu_bus.fetch)
    );

    // combinational decode
    control_unit cu0 (
        .cu_if (cu_bus.cu)
    );

    // stage 2, issue register
    issue_router router0 (
        .clk         (clk),
        .rst         (rst),
        .is_if       (cu_bus.issue),
        .s_issue     (s_issue),
        .m_issue     (m_issue),
        .illegal     (illegal),
        .halted      (halted),
        .alu_op      (alu_op),
        .fu_s        (fu_s),
        .fu_m        (fu_m),
        .branch_type (branch_type),
        .s_mem_type  (s_mem_type),
        .m_mem_type  (m_mem_type),
        .imm         (imm),
        .reg_write   (reg_write),
        .i_flag      (i_flag),
        .jal         (jal),
        .jalr        (jalr),
        .u_type      (u_type),
        .stride      (stride),
        .matrix_rs1  (matrix_rs1),
        .matrix_rd   (matrix_rd)
    );

endmodule

/* decode_stage_assert.sv */
// concurrent checks on the issue outputs of the decode stage
// bound to the top level
module decode_stage_assert (
    input logic clk,
    input logic rst,
    input logic s_issue,
    input logic m_issue,
    input logic illegal,
    input logic halted
);

    // one issue class per cycle
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({s_issue, m_issue, illegal}))
    else $error("s_issue, m_issue and illegal high together");

    // sticky until reset
    assert property (@(posedge clk) $fell(halted) |-> $past(rst))
    else $error("halted fell without reset");

    // pipeline is empty two cycles after the halt
    assert property (@(posedge clk) disable iff (rst)
        $past(halted, 2) |-> !(s_issue || m_issue || illegal))
    else $error("issue pulse long after halted rose");

endmodule

bind decode_stage decode_stage_assert assert0 (
    .clk     (clk),
    .rst     (rst),
    .s_issue (s_issue),
    .m_issue (m_issue),
    .illegal (illegal),
    .halted  (halted)
);

/* instr_fetch_reg.sv */
// input register for the decode stage
// latches the instruction on its strobe and stops for good after a halt
module instr_fetch_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  types_pkg::word_t  in_instr,
    control_unit_if.fetch     fe_if
);

    types_pkg::word_t instr_q;
    logic             valid_q;
    logic             stopped;
    logic             halt_seen;
    logic             accept;

    // halt currently sitting in the register
    assign halt_seen = fe_if.instr_valid && fe_if.halt;

    // drop strobes on the halt cycle itself and forever after
    assign accept = in_valid && !stopped && !halt_seen;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            instr_q <= '0;
            valid_q <= 1'b0;
            stopped <= 1'b0;
        end
        else
        begin
            valid_q <= accept;
            if (accept)
            begin
                instr_q <= in_instr;
            end
            if (halt_seen)
            begin
                stopped <= 1'b1;
            end
        end
    end

    assign fe_if.instr       = instr_q;
    assign fe_if.instr_valid = valid_q;

endmodule

/* issue_router.sv */
// output register of the decode stage
// pulses scalar issue, matrix issue or illegal, and holds the halted level
module issue_router (
    input  logic                  clk,
    input  logic                  rst,
    control_unit_if.issue         is_if,
    output logic                  s_issue,
    output logic                  m_issue,
    output logic                  illegal,
    output logic                  halted,
    output types_pkg::alu_op_t    alu_op,
    output types_pkg::fu_t        fu_s,
    output types_pkg::fu_t        fu_m,
    output types_pkg::branch_t    branch_type,
    output types_pkg::mem_t       s_mem_type,
    output types_pkg::mem_t       m_mem_type,
    output types_pkg::word_t      imm,
    output logic                  reg_write,
    output logic                  i_flag,
    output logic                  jal,
    output logic                  jalr,
    output types_pkg::u_type_t    u_type,
    output types_pkg::reg_idx_t   stride,
    output types_pkg::reg_idx_t   matrix_rs1,
    output types_pkg::mreg_idx_t  matrix_rd
);

    logic s_hit;
    logic m_hit;

    // lui has no unit but still writes a register
    assign s_hit = (is_if.fu_s != types_pkg::FU_NONE) || is_if.reg_write;
    assign m_hit = is_if.fu_m != types_pkg::FU_NONE;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_issue <= 1'b0;
            m_issue <= 1'b0;
            illegal <= 1'b0;
            halted  <= 1'b0;
        end
        else
        begin
            s_issue <= is_if.instr_valid && s_hit;
            m_issue <= is_if.instr_valid && m_hit;
            illegal <= is_if.instr_valid && !s_hit && !m_hit && !is_if.halt;
            if (is_if.instr_valid && is_if.halt)
            begin
                halted <= 1'b1;
            end
        end
    end

    // decoded fields, held between pulses
    always_ff @(posedge clk)
    begin
        if (is_if.instr_valid)
        begin
            alu_op      <= is_if.alu_op;
            fu_s        <= is_if.fu_s;
            fu_m        <= is_if.fu_m;
            branch_type <= is_if.branch_type;
            s_mem_type  <= is_if.s_mem_type;
            m_mem_type  <= is_if.m_mem_type;
            imm         <= is_if.imm;
            reg_write   <= is_if.reg_write;
            i_flag      <= is_if.i_flag;
            jal         <= is_if.jal;
            jalr        <= is_if.jalr;
            u_type      <= is_if.u_type;
            stride      <= is_if.stride;
            matrix_rs1  <= is_if.matrix_rs1;
            matrix_rd   <= is_if.matrix_rd;
        end
    end

endmodule

/* tb_decode_stage.sv */
// testbench for the decode stage
// random instructions from a fixed seed checked against a reference decoder
module tb_decode_stage;

    localparam int NUM_INSTR  = 400;
    localparam int TAIL_INSTR = 6;
    localparam int MAX_CYCLES = 4 * NUM_INSTR + 100;

    localparam types_pkg::opcode_t OPS [11] = '{
        types_pkg::RTYPE, types_pkg::ITYPE, types_pkg::ITYPE_LW, types_pkg::STYPE,
        types_pkg::BTYPE, types_pkg::JAL, types_pkg::JALR, types_pkg::LUI,
        types_pkg::LD_M, types_pkg::ST_M, types_pkg::GEMM_M
    };

    // kind is {s_issue, m_issue, illegal}
    typedef struct packed {
        logic [2:0]           kind;
        types_pkg::alu_op_t   alu_op;
        types_pkg::fu_t       fu_s;
        types_pkg::fu_t       fu_m;
        types_pkg::branch_t   branch_type;
        types_pkg::mem_t      s_mem_type;
        types_pkg::mem_t      m_mem_type;
        types_pkg::word_t     imm;
        logic                 reg_write;
        logic                 i_flag;
        logic                 jal;
        logic                 jalr;
        types_pkg::u_type_t   u_type;
        types_pkg::reg_idx_t  stride;
        types_pkg::reg_idx_t  matrix_rs1;
        types_pkg::mreg_idx_t matrix_rd;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    types_pkg::word_t     in_instr;
    logic                 s_issue;
    logic                 m_issue;
    logic                 illegal;
    logic                 halted;
    types_pkg::alu_op_t   alu_op;
    types_pkg::fu_t       fu_s;
    types_pkg::fu_t       fu_m;
    types_pkg::branch_t   branch_type;
    types_pkg::mem_t      s_mem_type;
    types_pkg::mem_t      m_mem_type;
    types_pkg::word_t     imm;
    logic                 reg_write;
    logic                 i_flag;
    logic                 jal;
    logic                 jalr;
    types_pkg::u_type_t   u_type;
    types_pkg::reg_idx_t  stride;
    types_pkg::reg_idx_t  matrix_rs1;
    types_pkg::mreg_idx_t matrix_rd;

    integer     seed = 32'h99f9;
    int         errors = 0;
    int         cycles = 0;
    int         accepted = 0;
    int         pulses = 0;
    logic       halt_sent = 1'b0;
    logic       halted_prev = 1'b0;
    logic [2:0] act_kind;
    expect_t    expq [$];

    decode_stage dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles, halt never drained", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic types_pkg::alu_op_t alu_model(logic [2:0] f3, logic alt, logic is_reg);
        types_pkg::alu_op_t r;
        case (f3)
            3'd0: r = (alt && is_reg) ? types_pkg::ALU_SUB : types_pkg::ALU_ADD;
            3'd1: r = types_pkg::ALU_SLL;
            3'd2: r = types_pkg::ALU_SLT;
            3'd3: r = types_pkg::ALU_SLTU;
            3'd4: r = types_pkg::ALU_XOR;
            3'd5: r = alt ? types_pkg::ALU_SRA : types_pkg::ALU_SRL;
            3'd6: r = types_pkg::ALU_OR;
            default: r = types_pkg::ALU_AND;
        endcase
        return r;
    endfunction

    // reference decoder, zero fields unless the opcode sets them
    function automatic expect_t decode_model(types_pkg::word_t w);
        expect_t          e;
        logic [6:0]       op;
        logic [2:0]       f3;
        logic             alt;
        types_pkg::word_t imm_i;
        e = '0;
        op = w[6:0];
        f3 = w[14:12];
        alt = (w[31:25] == 7'b0100000);
        imm_i = {{20{w[31]}}, w[31:20]};
        case (op)
            types_pkg::RTYPE, types_pkg::ITYPE:
            begin
                e.fu_s = types_pkg::FU_ALU;
                e.reg_write = 1'b1;
                e.i_flag = (op == types_pkg::ITYPE);
                e.imm = (op == types_pkg::ITYPE) ? imm_i : '0;
                e.alu_op = alu_model(f3, alt, op == types_pkg::RTYPE);
            end
            types_pkg::ITYPE_LW, types_pkg::STYPE:
            begin
                if (f3 == 3'd2)
                begin
                    e.fu_s = types_pkg::FU_LD_ST;
                    e.i_flag = 1'b1;
                    e.reg_write = (op == types_pkg::ITYPE_LW);
                    e.s_mem_type = e.reg_write ? types_pkg::MEM_LOAD : types_pkg::MEM_STORE;
                    e.imm = e.reg_write ? imm_i : {{20{w[31]}}, w[31:25], w[11:7]};
                end
            end
            types_pkg::BTYPE:
            begin
                e.fu_s = types_pkg::FU_BRANCH;
                e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                case (f3)
                    3'd0: e.branch_type = types_pkg::BR_BEQ;
                    3'd1: e.branch_type = types_pkg::BR_BNE;
                    3'd4: e.branch_type = types_pkg::BR_BLT;
                    3'd5: e.branch_type = types_pkg::BR_BGE;
                    3'd6: e.branch_type = types_pkg::BR_BLTU;
                    3'd7: e.branch_type = types_pkg::BR_BGEU;
                    default: e.branch_type = types_pkg::BR_NONE;
                endcase
            end
            types_pkg::JAL, types_pkg::JALR:
            begin
                e.fu_s = types_pkg::FU_ALU;
                e.reg_write = 1'b1;
                e.i_flag = 1'b1;
                e.jal = (op == types_pkg::JAL);
                e.jalr = !e.jal;
                e.imm = e.jal ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0} : imm_i;
            end
            types_pkg::LUI:
            begin
                e.reg_write = 1'b1;
                e.u_type = types_pkg::U_LOAD;
                e.imm = {w[31:12], 12'h000};
            end
            types_pkg::LD_M, types_pkg::ST_M:
            begin
                e.fu_m = types_pkg::FU_LD_ST;
                e.m_mem_type = (op == types_pkg::LD_M) ? types_pkg::MEM_LOAD
                                                       : types_pkg::MEM_STORE;
                e.imm = {{21{w[17]}}, w[17:7]};
                e.stride = w[22:18];
                e.matrix_rs1 = w[27:23];
                e.matrix_rd = w[31:28];
            end
            types_pkg::GEMM_M: e.fu_m = types_pkg::FU_GEMM;
            default: e = '0;
        endcase
        if (e.fu_s != types_pkg::FU_NONE || e.reg_write)
            e.kind = 3'b100;
        else if (e.fu_m != types_pkg::FU_NONE)
            e.kind = 3'b010;
        else
            e.kind = 3'b001;
        return e;
    endfunction

    // supported opcode with random fields, or a fully random word
    function automatic types_pkg::word_t random_instr();
        types_pkg::word_t w;
        int               pick;
        w = $random(seed);
        pick = $unsigned($random(seed)) % 14;
        if (pick > 10)
        begin
            // keep random words off the halt opcode
            if (w[6:0] == types_pkg::HALT)
                w[0] = 1'b0;
        end
        else
        begin
            w[6:0] = OPS[pick];
            if ((w[6:0] == types_pkg::RTYPE || w[6:0] == types_pkg::ITYPE) &&
                ($random(seed) % 4 != 0))
                w[31:25] = w[25] ? 7'b0100000 : 7'b0000000;
            if ((w[6:0] == types_pkg::ITYPE_LW || w[6:0] == types_pkg::STYPE) &&
                ($random(seed) % 8 != 0))
                w[14:12] = 3'd2;
        end
        return w;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act)
        else
        begin
            $display("ERROR %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic compare_outputs(input expect_t e, input logic [2:0] kind);
        check_field("{s_issue,m_issue,illegal}", 32'(e.kind), 32'(kind));
        check_field("alu_op", 32'(e.alu_op), 32'(alu_op));
        check_field("fu_s", 32'(e.fu_s), 32'(fu_s));
        check_field("fu_m", 32'(e.fu_m), 32'(fu_m));
        check_field("branch_type", 32'(e.branch_type), 32'(branch_type));
        check_field("s_mem_type", 32'(e.s_mem_type), 32'(s_mem_type));
        check_field("m_mem_type", 32'(e.m_mem_type), 32'(m_mem_type));
        check_field("imm", e.imm, imm);
        check_field("reg_write", 32'(e.reg_write), 32'(reg_write));
        check_field("i_flag", 32'(e.i_flag), 32'(i_flag));
        check_field("jal", 32'(e.jal), 32'(jal));
        check_field("jalr", 32'(e.jalr), 32'(jalr));
        check_field("u_type", 32'(e.u_type), 32'(u_type));
        check_field("stride", 32'(e.stride), 32'(stride));
        check_field("matrix_rs1", 32'(e.matrix_rs1), 32'(matrix_rs1));
        check_field("matrix_rd", 32'(e.matrix_rd), 32'(matrix_rd));
    endtask

    // outputs are sampled away from the rising edge
    always @(negedge clk)
    begin
        if (cycles > 0)
        begin
            act_kind = {s_issue, m_issue, illegal};
            if (rst)
            begin
                assert (act_kind == 3'b000 && !halted)
                else
                begin
                    $display("issue or halted output set during reset");
                    errors++;
                end
            end
            else
            begin
                assert ($countones(act_kind) <= 1)
                else
                begin
                    $display("more than one issue output high at once");
                    errors++;
                end
                assert (!(halted_prev && !halted) && (!halted || halt_sent))
                else
                begin
                    $display("halted changed without a halt or a reset");
                    errors++;
                end
                if (act_kind != 3'b000)
                begin
                    pulses++;
                    assert (expq.size() > 0)
                    else
                    begin
                        $display("issue pulse with no instruction pending");
                        errors++;
                    end
                    if (expq.size() > 0)
                        compare_outputs(expq.pop_front(), act_kind);
                end
            end
            halted_prev = halted;
        end
    end

    initial
    begin
        types_pkg::word_t w;
        int               sent;
        rst = 1'b1;
        // a halt held on the input during reset must be ignored
        in_valid = 1'b1;
        in_instr = {25'h0, types_pkg::HALT};
        sent = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        in_valid <= 1'b0;
        while (sent < NUM_INSTR)
        begin
            @(posedge clk);
            if (($random(seed) & 3) != 0)
            begin
                w = random_instr();
                expq.push_back(decode_model(w));
                accepted++;
                sent++;
                in_valid <= 1'b1;
                in_instr <= w;
            end
            else
            begin
                in_valid <= 1'b0;
                in_instr <= $random(seed);
            end
        end
        // halt, then a burst that must be dropped
        @(posedge clk);
        w = $random(seed);
        w[6:0] = types_pkg::HALT;
        in_valid <= 1'b1;
        in_instr <= w;
        halt_sent = 1'b1;
        repeat (TAIL_INSTR)
        begin
            @(posedge clk);
            in_instr <= random_instr();
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (!halted)
            @(posedge clk);
        repeat (4) @(posedge clk);
        check_field("issue pulse count", 32'(accepted), 32'(pulses));
        assert (expq.size() == 0)
        else
        begin
            $display("%0d decoded instructions never issued", expq.size());
            errors++;
        end
        $display("errors: %0d, instructions: %0d, pulses: %0d", errors, accepted, pulses);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* types_pkg.sv */
// word typedefs, opcode and funct constants, and the decode enums
// shared by the decode stage and its testbench
package types_pkg;

    // plain vectors
    typedef logic [31:0] word_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  mreg_idx_t;

    // major opcodes, rv32i subset
    localparam opcode_t RTYPE    = 7'b0110011;
    localparam opcode_t ITYPE    = 7'b0010011;
    localparam opcode_t ITYPE_LW = 7'b0000011;
    localparam opcode_t STYPE    = 7'b0100011;
    localparam opcode_t BTYPE    = 7'b1100011;
    localparam opcode_t JAL      = 7'b1101111;
    localparam opcode_t JALR     = 7'b1100111;
    localparam opcode_t LUI      = 7'b0110111;
    localparam opcode_t HALT     = 7'b1111111;

    // matrix extension
    localparam opcode_t LD_M     = 7'b1000111;
    localparam opcode_t ST_M     = 7'b1010111;
    localparam opcode_t GEMM_M   = 7'b1110111;

    // funct3 for alu ops, shared by r-type and i-type
    localparam logic [2:0] ADD_SUB = 3'b000;
    localparam logic [2:0] SLL     = 3'b001;
    localparam logic [2:0] SLT     = 3'b010;
    localparam logic [2:0] SLTU    = 3'b011;
    localparam logic [2:0] XOR     = 3'b100;
    localparam logic [2:0] SRL_SRA = 3'b101;
    localparam logic [2:0] OR      = 3'b110;
    localparam logic [2:0] AND     = 3'b111;

    // funct3 for branches
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

    // word access is the only load/store width supported
    localparam logic [2:0] LW_SW = 3'b010;

    // funct7 selecting the alternate alu op
    localparam logic [6:0] SUB = 7'b0100000;
    localparam logic [6:0] SRA = 7'b0100000;

    // functional unit select
    typedef enum logic [2:0] {
        FU_NONE, FU_ALU, FU_LD_ST, FU_BRANCH, FU_GEMM
    } fu_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_t;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_t;

    // auipc not supported, so only the load form remains
    typedef enum logic {
        U_NONE, U_LOAD
    } u_type_t;

endpackage
